// File: intExecUnit.f
coreTypesPkg.sv
execPkg.sv
leadZeroCount.sv
popCount.sv
branchResolve.sv
intAlu.sv
intExecUnit.sv
intExecUnit_assertions.sv
intExecUnitTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= intExecUnitTb
FILELIST ?= intExecUnit.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: intExecUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

module intExecUnitTb;

    import coreTypesPkg::*;
    import execPkg::*;

    localparam int NUM_UOPS = 2000;
    localparam longint TIMEOUT_NS = longint'(NUM_UOPS) * 64'd10 * 64'd4;

    logic clk;
    logic rst;
    ExUop uop;
    logic uopValid;
    logic uopReady;
    logic invalidate;
    SqN invalidateSqN;
    ResUop res;
    logic resValid;
    logic resReady;
    BranchProv branch;
    BtUpdate btUpdate;
    Word fwdResult;
    Tag fwdTag;
    logic fwdValid;

    int seed = 65;
    int accepted = 0;
    SqN sqCounter = '0;
    ResUop expQ[$];
    BranchProv expBranch;
    BtUpdate expBt;

    intExecUnit i_dut (
        .clk(clk),
        .rst(rst),
        .uop(uop),
        .uopValid(uopValid),
        .uopReady(uopReady),
        .invalidate(invalidate),
        .invalidateSqN(invalidateSqN),
        .res(res),
        .resValid(resValid),
        .resReady(resReady),
        .branch(branch),
        .btUpdate(btUpdate),
        .fwdResult(fwdResult),
        .fwdTag(fwdTag),
        .fwdValid(fwdValid)
    );

    always #2 clk = ~clk;

    task automatic failRun();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic checkResult(input string name, input ResUop exp, input ResUop act);
        if (exp !== act) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            failRun();
        end
    endtask

    task automatic checkBranch(input string name, input BranchProv exp, input BranchProv act);
        if (act.valid !== exp.valid || (exp.valid && exp !== act)) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            failRun();
        end
    endtask

    task automatic checkBtUpdate(input string name, input BtUpdate exp, input BtUpdate act);
        if (act.valid !== exp.valid || (exp.valid && exp !== act)) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            failRun();
        end
    endtask

    task automatic checkWord(input string name, input Word exp, input Word act);
        if (exp !== act) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            failRun();
        end
    endtask

    task automatic checkTag(input string name, input Tag exp, input Tag act);
        if (exp !== act) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            failRun();
        end
    endtask

    task automatic checkBit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("FAILED %s: expected %b, actual %b", name, exp, act);
            failRun();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // reference model.
    ////////////////////////////////////////////////////////////

    function automatic logic younger(input SqN a, input SqN b);
        SqN d;
        d = a - b;
        return $signed(d) > 0;
    endfunction

    function automatic logic isCond(input ExUop u);
        return u.opcode inside {INT_BEQ, INT_BNE, INT_BLT, INT_BGE, INT_BLTU, INT_BGEU};
    endfunction

    function automatic Word linkPc(input ExUop u);
        return u.pc + (u.compressed ? 32'd2 : 32'd4);
    endfunction

    function automatic logic modelTaken(input ExUop u);
        case (u.opcode)
            INT_BEQ:  return u.srcA == u.srcB;
            INT_BNE:  return u.srcA != u.srcB;
            INT_BLT:  return $signed(u.srcA) < $signed(u.srcB);
            INT_BGE:  return $signed(u.srcA) >= $signed(u.srcB);
            INT_BLTU: return u.srcA < u.srcB;
            INT_BGEU: return u.srcA >= u.srcB;
            INT_JAL,
            INT_JALR: return 1'b1;
            default:  return 1'b0;
        endcase
    endfunction

    function automatic Word modelTarget(input ExUop u);
        if (u.opcode == INT_JALR) return u.srcA + u.srcB;
        if (!modelTaken(u)) return linkPc(u);
        if (u.opcode == INT_JAL) return u.pc + u.imm;
        return u.pc + {{19{u.imm[12]}}, u.imm[12:0]};
    endfunction

    function automatic Word modelResult(input ExUop u);
        Word a;
        Word b;
        Word r;
        int n;
        a = u.srcA;
        b = u.srcB;
        r = '0;
        n = 0;
        case (u.opcode)
            INT_ADD:    r = a + b;
            INT_SUB:    r = a - b;
            INT_XOR:    r = a ^ b;
            INT_OR:     r = a | b;
            INT_AND:    r = a & b;
            INT_SLL:    r = a << b[4:0];
            INT_SRL:    r = a >> b[4:0];
            INT_SRA:    r = $signed(a) >>> b[4:0];
            INT_SLT:    r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            INT_SLTU:   r = (a < b) ? 32'd1 : 32'd0;
            INT_LUI:    r = b;
            INT_AUIPC:  r = u.pc + u.imm;
            INT_SH1ADD: r = b + (a << 1);
            INT_SH2ADD: r = b + (a << 2);
            INT_SH3ADD: r = b + (a << 3);
            INT_ANDN:   r = a & ~b;
            INT_ORN:    r = a | ~b;
            INT_XNOR:   r = ~(a ^ b);
            INT_SEXT_B: r = {{24{a[7]}}, a[7:0]};
            INT_SEXT_H: r = {{16{a[15]}}, a[15:0]};
            INT_ZEXT_H: r = {16'h0, a[15:0]};
            INT_CLZ: begin
                n = 32;
                for (int i = 0; i < 32; i++) if (a[i]) n = 31 - i;
                r = Word'(n);
            end
            INT_CTZ: begin
                n = 32;
                for (int i = 31; i >= 0; i--) if (a[i]) n = i;
                r = Word'(n);
            end
            INT_CPOP: begin
                for (int i = 0; i < 32; i++) n += int'(a[i]);
                r = Word'(n);
            end
            INT_ORC_B:
                for (int k = 0; k < 4; k++) r[8*k +: 8] = (a[8*k +: 8] != 8'h0) ? 8'hff : 8'h0;
            INT_REV8:
                for (int k = 0; k < 4; k++) r[8*k +: 8] = a[8*(3-k) +: 8];
            INT_MIN:    r = ($signed(a) < $signed(b)) ? a : b;
            INT_MAX:    r = ($signed(a) < $signed(b)) ? b : a;
            INT_MINU:   r = (a < b) ? a : b;
            INT_MAXU:   r = (a < b) ? b : a;
            INT_JAL,
            INT_JALR:   r = linkPc(u);
            default:    r = '0;
        endcase
        return r;
    endfunction

    function automatic ResFlags modelFlags(input ExUop u);
        if (!isCond(u)) return FLAGS_NONE;
        if (!u.predicted) return FLAGS_BRANCH;
        return modelTaken(u) ? FLAGS_PRED_TAKEN : FLAGS_PRED_NTAKEN;
    endfunction

    ////////////////////////////////////////////////////////////
    // stimulus.
    ////////////////////////////////////////////////////////////

    // operands lean toward equal and zero values.
    function automatic ExUop randomUop(input SqN sq);
        ExUop u;
        logic [31:0] r;
        r = $random(seed);
        u.opcode = IntOp'(6'(r % 32'd38));
        u.srcA = $random(seed);
        u.srcB = $random(seed);
        r = $random(seed);
        if (r[1:0] == 2'd0) u.srcB = u.srcA;
        if (r[1:0] == 2'd1) u.srcA = '0;
        u.imm = $random(seed);
        u.pc = $random(seed) & ~32'd1;
        r = $random(seed);
        u.tagDst = r[6:0];
        u.nmDst = r[11:7];
        u.compressed = r[12];
        u.predTaken = r[13];
        u.predicted = r[14];
        u.sqN = sq;
        return u;
    endfunction

    task automatic checkCycle();
        logic expReady;
        logic squash;
        ResUop expRes;
        if (expQ.size() > 0) begin
            if (invalidate && younger(expQ[0].sqN, invalidateSqN)) begin
                checkBit("dropped result valid", 1'b0, resValid);
                void'(expQ.pop_front());
            end else begin
                checkBit("result valid", 1'b1, resValid);
                checkResult("result", expQ[0], res);
                if (resReady) void'(expQ.pop_front());
            end
        end else begin
            checkBit("idle result valid", 1'b0, resValid);
        end
        expReady = (expQ.size() == 0);
        checkBit("uopReady", expReady, uopReady);
        checkBranch("branch", expBranch, branch);
        checkBtUpdate("btUpdate", expBt, btUpdate);
        expBranch = '0;
        expBt = '0;
        if (uopValid && expReady) begin
            accepted++;
            squash = invalidate && younger(uop.sqN, invalidateSqN);
            checkBit("fwdValid", !squash && uop.nmDst != '0, fwdValid);
            if (!squash) begin
                if (uop.nmDst != '0) begin
                    checkWord("fwdResult", modelResult(uop), fwdResult);
                    checkTag("fwdTag", uop.tagDst, fwdTag);
                end
                expRes = '{result: modelResult(uop), tagDst: uop.tagDst,
                           nmDst: uop.nmDst, sqN: uop.sqN, pc: uop.pc,
                           compressed: uop.compressed, flags: modelFlags(uop)};
                expQ.push_back(expRes);
                expBranch.valid = (isCond(uop) && modelTaken(uop) != uop.predTaken)
                                  || uop.opcode == INT_JALR;
                expBranch.sqN = uop.sqN;
                expBranch.dstPC = modelTarget(uop);
                expBt.valid = (isCond(uop) || uop.opcode == INT_JAL) && modelTaken(uop)
                              && !uop.predicted;
                expBt.src = uop.compressed ? uop.pc : uop.pc + 32'd2;
                expBt.dst = modelTarget(uop);
                expBt.isJump = (uop.opcode == INT_JAL);
                expBt.compressed = uop.compressed;
            end
        end else begin
            checkBit("idle fwdValid", 1'b0, fwdValid);
        end
    endtask

    initial begin
        logic [31:0] r;
        clk = 1'b0;
        rst = 1'b0;
        uop = '0;
        uopValid = 1'b0;
        invalidate = 1'b0;
        invalidateSqN = '0;
        resReady = 1'b0;
        expBranch = '0;
        expBt = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b1;
        while (accepted < NUM_UOPS) begin
            @(posedge clk);
            r = $random(seed);
            uop <= randomUop(sqCounter);
            uopValid <= (r[1:0] != 2'd0);
            resReady <= (r[3:2] != 2'd0);
            invalidate <= (r[6:4] == 3'd0);
            invalidateSqN <= sqCounter - SqN'(r[9:8]);
            sqCounter = sqCounter + SqN'(1);
            @(negedge clk);
            checkCycle();
        end
        // drain the last result and pulses.
        @(posedge clk);
        uopValid <= 1'b0;
        resReady <= 1'b1;
        invalidate <= 1'b0;
        @(negedge clk);
        checkCycle();
        $display("sim passed");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish in the expected time");
        failRun();
    end

endmodule

`default_nettype wire

// File: intExecUnit_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module intExecUnit_assertions (
    input wire clk,
    input wire rst,
    input wire uopValid,
    input wire uopReady,
    input wire execPkg::ResUop res,
    input wire resValid,
    input wire resReady,
    input wire execPkg::BranchProv branch,
    input wire execPkg::BtUpdate btUpdate
);

    import execPkg::*;

    // quiet outputs one cycle into reset.
    resetQuiet: assert property (@(posedge clk)
        !rst |=> !resValid && !branch.valid && !btUpdate.valid && uopReady)
        else $error("outputs active after reset");

    // held result must not move.
    holdStable: assert property (@(posedge clk) disable iff (!rst)
        resValid && !resReady |=> $stable(res))
        else $error("result changed under back-pressure");

    singlePulse: assert property (@(posedge clk) disable iff (!rst)
        branch.valid |=> !branch.valid || (branch.sqN != $past(branch.sqN)))
        else $error("branch pulse repeated for one result");

    // a result comes only from an accepted op or one still held.
    noPhantom: assert property (@(posedge clk) disable iff (!rst)
        resValid |-> $past(uopValid && uopReady) || $past(resValid && !resReady))
        else $error("result without acceptance");

endmodule

bind intExecUnit intExecUnit_assertions i_checks (
    .clk(clk),
    .rst(rst),
    .uopValid(uopValid),
    .uopReady(uopReady),
    .res(res),
    .resValid(resValid),
    .resReady(resReady),
    .branch(branch),
    .btUpdate(btUpdate)
);

`default_nettype wire

// File: intExecUnit.sv
`timescale 1ns/1ps
`default_nettype none

module intExecUnit (
    input wire clk,
    input wire rst,
    input wire execPkg::ExUop uop,
    input wire uopValid,
    output logic uopReady,
    input wire invalidate,
    input wire coreTypesPkg::SqN invalidateSqN,
    output execPkg::ResUop res,
    output logic resValid,
    input wire resReady,
    output execPkg::BranchProv branch,
    output execPkg::BtUpdate btUpdate,
    output coreTypesPkg::Word fwdResult,
    output coreTypesPkg::Tag fwdTag,
    output logic fwdValid
);

    // single integer slot.
    intAlu i_alu (
        .clk(clk),
        .rst(rst),
        .uop(uop),
        .uopValid(uopValid),
        .uopReady(uopReady),
        .invalidate(invalidate),
        .invalidateSqN(invalidateSqN),
        .res(res),
        .resValid(resValid),
        .resReady(resReady),
        .branch(branch),
        .btUpdate(btUpdate),
        .fwdResult(fwdResult),
        .fwdTag(fwdTag),
        .fwdValid(fwdValid)
    );

endmodule

`default_nettype wire

// File: intAlu.sv
`timescale 1ns/1ps
`default_nettype none

module intAlu (
    input wire clk,
    input wire rst,
    input wire execPkg::ExUop uop,
    input wire uopValid,
    output logic uopReady,
    input wire invalidate,
    input wire coreTypesPkg::SqN invalidateSqN,
    output execPkg::ResUop res,
    output logic resValid,
    input wire resReady,
    output execPkg::BranchProv branch,
    output execPkg::BtUpdate btUpdate,
    output coreTypesPkg::Word fwdResult,
    output coreTypesPkg::Tag fwdTag,
    output logic fwdValid
);

    import coreTypesPkg::*;
    import execPkg::*;

    localparam int CNT_W = $clog2($bits(Word)) + 1;

    Word srcA;
    Word srcB;
    Word srcARev;
    Word result;
    logic [CNT_W-1:0] lzCount;
    logic [CNT_W-1:0] onesCount;
    logic lessThan;
    logic lessThanU;
    logic taken;
    logic isBranch;
    logic mispredict;
    Word target;
    BtUpdate btNext;
    ResFlags flags;
    logic accept;
    logic squash;
    logic resHeld;
    ResUop resReg;
    logic branchValid;
    BranchProv branchReg;
    logic btValid;
    BtUpdate btReg;

    // a is younger than b.
    function automatic logic isYounger(input SqN a, input SqN b);
        SqN diff;
        diff = a - b;
        return $signed(diff) > 0;
    endfunction

    assign srcA = uop.srcA;
    assign srcB = uop.srcB;
    assign lessThan = ($signed(srcA) < $signed(srcB));
    assign lessThanU = (srcA < srcB);

    ////////////////////////////////////////////////////////////
    // compute path.
    ////////////////////////////////////////////////////////////

    // ctz is clz of the mirrored operand.
    for (genvar i = 0; i < $bits(Word); i++) begin : gRev
        assign srcARev[i] = srcA[$bits(Word)-1-i];
    end

    leadZeroCount #(.WIDTH($bits(Word))) i_lzc (
        .in(uop.opcode == INT_CLZ ? srcA : srcARev),
        .count(lzCount)
    );

    popCount #(.WIDTH($bits(Word))) i_popc (
        .in(srcA),
        .count(onesCount)
    );

    branchResolve i_branch (
        .uop(uop),
        .lessThan(lessThan),
        .lessThanU(lessThanU),
        .taken(taken),
        .isBranch(isBranch),
        .target(target),
        .mispredict(mispredict),
        .btUpdate(btNext)
    );

    always_comb begin
        case (uop.opcode)
            INT_ADD:    result = srcA + srcB;
            INT_SUB:    result = srcA - srcB;
            INT_XOR:    result = srcA ^ srcB;
            INT_OR:     result = srcA | srcB;
            INT_AND:    result = srcA & srcB;
            INT_SLL:    result = srcA << srcB[4:0];
            INT_SRL:    result = srcA >> srcB[4:0];
            INT_SRA:    result = $signed(srcA) >>> srcB[4:0];
            INT_SLT:    result = Word'(lessThan);
            INT_SLTU:   result = Word'(lessThanU);
            // upper immediate arrives on operand b.
            INT_LUI:    result = srcB;
            INT_AUIPC:  result = uop.pc + uop.imm;
            INT_SH1ADD: result = srcB + (srcA << 1);
            INT_SH2ADD: result = srcB + (srcA << 2);
            INT_SH3ADD: result = srcB + (srcA << 3);
            INT_ANDN:   result = srcA & ~srcB;
            INT_ORN:    result = srcA | ~srcB;
            INT_XNOR:   result = ~(srcA ^ srcB);
            INT_SEXT_B: result = {{24{srcA[7]}}, srcA[7:0]};
            INT_SEXT_H: result = {{16{srcA[15]}}, srcA[15:0]};
            INT_ZEXT_H: result = {16'b0, srcA[15:0]};
            INT_CLZ,
            INT_CTZ:    result = Word'(lzCount);
            INT_CPOP:   result = Word'(onesCount);
            INT_ORC_B:  result = {{8{|srcA[31:24]}}, {8{|srcA[23:16]}},
                                  {8{|srcA[15:8]}}, {8{|srcA[7:0]}}};
            INT_MIN:    result = lessThan ? srcA : srcB;
            INT_MAX:    result = lessThan ? srcB : srcA;
            INT_MINU:   result = lessThanU ? srcA : srcB;
            INT_MAXU:   result = lessThanU ? srcB : srcA;
            INT_REV8:   result = {srcA[7:0], srcA[15:8], srcA[23:16], srcA[31:24]};
            // link address.
            INT_JAL,
            INT_JALR:   result = uop.pc + (uop.compressed ? 32'd2 : 32'd4);
            default:    result = '0;
        endcase
    end

    always_comb begin
        if (isBranch && uop.opcode != INT_JAL) begin
            if (uop.predicted) begin
                flags = taken ? FLAGS_PRED_TAKEN : FLAGS_PRED_NTAKEN;
            end else begin
                flags = FLAGS_BRANCH;
            end
        end else begin
            flags = FLAGS_NONE;
        end
    end

    ////////////////////////////////////////////////////////////
    // handshake, squash and output stage.
    ////////////////////////////////////////////////////////////

    assign squash = invalidate && isYounger(uop.sqN, invalidateSqN);
    assign accept = uopValid && uopReady;

    // held result is killed as soon as it turns younger than an invalidation.
    assign resValid = resHeld && !(invalidate && isYounger(resReg.sqN, invalidateSqN));
    assign uopReady = !resValid || resReady;

    assign fwdResult = result;
    assign fwdTag = uop.tagDst;
    assign fwdValid = accept && !squash && (uop.nmDst != '0);

    always_ff @(posedge clk) begin
        if (!rst) begin
            resHeld <= 1'b0;
            branchValid <= 1'b0;
            btValid <= 1'b0;
        end else begin
            branchValid <= accept && !squash && mispredict;
            btValid <= accept && !squash && btNext.valid;
            if (accept && !squash) begin
                resHeld <= 1'b1;
            end else if (uopReady) begin
                resHeld <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !squash) begin
            resReg <= '{result: result, tagDst: uop.tagDst, nmDst: uop.nmDst, sqN: uop.sqN,
                        pc: uop.pc, compressed: uop.compressed, flags: flags};
            branchReg <= '{valid: 1'b1, sqN: uop.sqN, dstPC: target};
            btReg <= btNext;
        end
    end

    assign res = resReg;

    always_comb begin
        branch = branchReg;
        branch.valid = branchValid;
        btUpdate = btReg;
        btUpdate.valid = btValid;
    end

endmodule

`default_nettype wire

// File: branchResolve.sv
`timescale 1ns/1ps
`default_nettype none

module branchResolve (
    input wire execPkg::ExUop uop,
    input wire lessThan,
    input wire lessThanU,
    output logic taken,
    output logic isBranch,
    output coreTypesPkg::Word target,
    output logic mispredict,
    output execPkg::BtUpdate btUpdate
);

    import coreTypesPkg::*;
    import execPkg::*;

    logic isCond;
    logic equal;
    Word pcNext;
    Word branchOffset;

    assign equal = (uop.srcA == uop.srcB);
    assign pcNext = uop.pc + (uop.compressed ? 32'd2 : 32'd4);

    // b-type immediate is 13 bits.
    assign branchOffset = {{19{uop.imm[12]}}, uop.imm[12:0]};

    always_comb begin
        isCond = 1'b1;
        case (uop.opcode)
            INT_BEQ:  taken = equal;
            INT_BNE:  taken = !equal;
            INT_BLT:  taken = lessThan;
            INT_BGE:  taken = !lessThan;
            INT_BLTU: taken = lessThanU;
            INT_BGEU: taken = !lessThanU;
            INT_JAL,
            INT_JALR: begin
                taken = 1'b1;
                isCond = 1'b0;
            end
            default: begin
                taken = 1'b0;
                isCond = 1'b0;
            end
        endcase
    end

    // jalr is never predicted by the front end.
    assign isBranch = isCond || (uop.opcode == INT_JAL);

    always_comb begin
        if (uop.opcode == INT_JALR) begin
            target = uop.srcA + uop.srcB;
        end else if (!taken) begin
            target = pcNext;
        end else if (uop.opcode == INT_JAL) begin
            target = uop.pc + uop.imm;
        end else begin
            target = uop.pc + branchOffset;
        end
    end

    assign mispredict = (isCond && (taken != uop.predTaken)) || (uop.opcode == INT_JALR);

    // full size ops are looked up by their second halfword.
    always_comb begin
        btUpdate.valid = isBranch && taken && !uop.predicted;
        btUpdate.src = uop.compressed ? uop.pc : uop.pc + 32'd2;
        btUpdate.dst = target;
        btUpdate.isJump = (uop.opcode == INT_JAL);
        btUpdate.compressed = uop.compressed;
    end

endmodule

`default_nettype wire

// File: popCount.sv
`timescale 1ns/1ps
`default_nettype none

module popCount #(
    parameter int WIDTH = $bits(coreTypesPkg::Word)
) (
    input wire [WIDTH-1:0] in,
    output logic [$clog2(WIDTH):0] count
);

    localparam int CNT_W = $clog2(WIDTH) + 1;

    // heap layout, leaves at WIDTH.. and root at 1.
    logic [CNT_W-1:0] node [1:2*WIDTH-1];

    // children are summed before their parent.
    always_comb begin
        for (int i = 0; i < WIDTH; i++) begin
            node[WIDTH+i] = CNT_W'(in[i]);
        end
        for (int k = WIDTH - 1; k >= 1; k--) begin
            node[k] = node[2*k] + node[2*k+1];
        end
    end

    assign count = node[1];

endmodule

`default_nettype wire

// File: leadZeroCount.sv
`timescale 1ns/1ps
`default_nettype none

module leadZeroCount #(
    parameter int WIDTH = $bits(coreTypesPkg::Word)
) (
    input wire [WIDTH-1:0] in,
    output logic [$clog2(WIDTH):0] count
);

    localparam int LOG = $clog2(WIDTH);

    logic [WIDTH-1:0] shifted;
    logic [LOG-1:0] pos;

    // binary search, halving the window each level.
    always_comb begin
        shifted = in;
        for (int i = LOG - 1; i >= 0; i--) begin
            if ((shifted >> (WIDTH - (1 << i))) == '0) begin
                pos[i] = 1'b1;
                shifted = shifted << (1 << i);
            end else begin
                pos[i] = 1'b0;
            end
        end
    end

    // all zero input counts as full width.
    assign count = (in == '0) ? (LOG + 1)'(WIDTH) : {1'b0, pos};

endmodule

`default_nettype wire

// File: execPkg.sv
`default_nettype none

package execPkg;

    ////////////////////////////////////////////////////////////
    // integer opcodes.
    ////////////////////////////////////////////////////////////

    typedef enum logic [5:0] {
        // rv32i alu.
        INT_ADD,
        INT_SUB,
        INT_XOR,
        INT_OR,
        INT_AND,
        INT_SLL,
        INT_SRL,
        INT_SRA,
        INT_SLT,
        INT_SLTU,
        INT_LUI,
        INT_AUIPC,
        // zba / zbb.
        INT_SH1ADD,
        INT_SH2ADD,
        INT_SH3ADD,
        INT_ANDN,
        INT_ORN,
        INT_XNOR,
        INT_SEXT_B,
        INT_SEXT_H,
        INT_ZEXT_H,
        INT_CLZ,
        INT_CTZ,
        INT_CPOP,
        INT_ORC_B,
        INT_MIN,
        INT_MAX,
        INT_MINU,
        INT_MAXU,
        INT_REV8,
        // jumps and branches.
        INT_JAL,
        INT_JALR,
        INT_BEQ,
        INT_BNE,
        INT_BLT,
        INT_BGE,
        INT_BLTU,
        INT_BGEU
    } IntOp;

    // tells commit how the op was predicted.
    typedef enum logic [1:0] {
        FLAGS_NONE,
        FLAGS_BRANCH,
        FLAGS_PRED_TAKEN,
        FLAGS_PRED_NTAKEN
    } ResFlags;

    ////////////////////////////////////////////////////////////
    // micro-op and output records.
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        coreTypesPkg::Word srcA;
        coreTypesPkg::Word srcB;
        coreTypesPkg::Word imm;
        coreTypesPkg::Word pc;
        IntOp opcode;
        coreTypesPkg::Tag tagDst;
        coreTypesPkg::RegName nmDst;
        coreTypesPkg::SqN sqN;
        logic compressed;
        logic predTaken;
        logic predicted;
    } ExUop;

    typedef struct packed {
        coreTypesPkg::Word result;
        coreTypesPkg::Tag tagDst;
        coreTypesPkg::RegName nmDst;
        coreTypesPkg::SqN sqN;
        coreTypesPkg::Word pc;
        logic compressed;
        ResFlags flags;
    } ResUop;

    // valid means redirect.
    typedef struct packed {
        logic valid;
        coreTypesPkg::SqN sqN;
        coreTypesPkg::Word dstPC;
    } BranchProv;

    typedef struct packed {
        logic valid;
        coreTypesPkg::Word src;
        coreTypesPkg::Word dst;
        logic isJump;
        logic compressed;
    } BtUpdate;

endpackage

`default_nettype wire

// File: coreTypesPkg.sv
`default_nettype none

package coreTypesPkg;

    ////////////////////////////////////////////////////////////
    // machine widths.
    ////////////////////////////////////////////////////////////

    // fixed by the isa.
    localparam int WORD_W = 32;

    // physical register file has 128 entries.
    localparam int TAG_W = 7;

    // x0..x31.
    localparam int REG_NAME_W = 5;

    // window of in-flight ops.
    localparam int SQN_W = 7;

    ////////////////////////////////////////////////////////////
    // plain vector types.
    ////////////////////////////////////////////////////////////

    // data word or pc.
    typedef logic [WORD_W-1:0] Word;

    // physical destination tag.
    typedef logic [TAG_W-1:0] Tag;

    // architectural register, zero means no destination.
    typedef logic [REG_NAME_W-1:0] RegName;

    // program order number, wraps. compare by signed difference.
    typedef logic [SQN_W-1:0] SqN;

endpackage

`default_nettype wire
